// ==== Bender.yml ====
package:
  name: ball_vision

sources:
  - rtl/video_stream_pkg.sv
  - rtl/ball_detect_pkg.sv
  - rtl/stream_reg.sv
  - rtl/rgb_to_hsv.sv
  - rtl/ball_classifier.sv
  - rtl/pixel_locator.sv
  - rtl/box_tracker.sv
  - rtl/frame_overlay.sv
  - rtl/vision_csr.sv
  - rtl/ball_vision_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/ball_vision_tb.sv

// ==== rtl/ball_classifier.sv ====
/* per-colour HSV window matching with a run filter
   a colour is confirmed only at the end of RUN_LEN matching pixels */
`timescale 1ns/10ps

module ball_classifier (
	input  logic clk,
	input  logic reset_n,
	input  ball_detect_pkg::hsv_t hsv,
	input  logic header,  // sop beat, not a pixel
	input  logic advance, // beat moves to the output stage
	output logic [ball_detect_pkg::NUM_BALLS-1:0] confirmed
);
	import ball_detect_pkg::*;

	logic [NUM_BALLS-1:0] match;
	logic [NUM_BALLS-1:0][RUN_LEN-2:0] hist; // previous matches, newest in bit 0

	function automatic logic in_win(input hsv_t p, input hsv_win_t w);
		in_win = (p.hue >= w.hue_lo) && (p.hue <= w.hue_hi) &&
			(p.sat >= w.sat_lo) && (p.sat <= w.sat_hi) &&
			(p.val >= w.val_lo) && (p.val <= w.val_hi);
	endfunction

	assign match[BALL_RED] = in_win(hsv, RED_WIN);
	assign match[BALL_ORANGE] = in_win(hsv, ORANGE_WIN_A) | in_win(hsv, ORANGE_WIN_B) |
		in_win(hsv, ORANGE_WIN_C) | in_win(hsv, ORANGE_WIN_D);
	assign match[BALL_TEAL] = in_win(hsv, TEAL_WIN);
	assign match[BALL_PINK] = in_win(hsv, PINK_WIN_HI) | in_win(hsv, PINK_WIN_LO); // hue wraps

	//////////////////////////////
	// run history
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			hist <= '0;
		end else if (advance) begin
			for (int c = 0; c < NUM_BALLS; c++) begin
				if (header) hist[c] <= '0; // runs never span packets
				else hist[c] <= {hist[c][RUN_LEN-3:0], match[c]};
			end
		end
	end

	always_comb begin
		for (int c = 0; c < NUM_BALLS; c++) begin
			confirmed[c] = match[c] & (&hist[c]) & ~header; // whole run matched
		end
	end

endmodule

// ==== rtl/ball_detect_pkg.sv ====
/* colour classes, HSV windows, overlay colours and CSR map of the ball detector
   import in the classifier, tracker, overlay and register port */
package ball_detect_pkg;

	typedef enum logic [1:0] {
		BALL_RED,
		BALL_ORANGE,
		BALL_TEAL,
		BALL_PINK
	} ball_color_e;

	localparam int NUM_BALLS = 4;
	localparam int RUN_LEN = 4; // matching pixels in a row before a colour counts

	typedef struct packed {
		logic [7:0] hue; // half degrees, 0..180
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	typedef struct packed {
		video_stream_pkg::coord_t left;
		video_stream_pkg::coord_t right;
	} box_t; // 22 bits

	localparam box_t BOX_EMPTY = '{left: 11'(video_stream_pkg::IMAGE_W - 1), right: 11'd0};

	//////////////////////////////
	// classification windows, all limits inclusive
	typedef struct packed {
		logic [7:0] hue_lo;
		logic [7:0] hue_hi;
		logic [7:0] sat_lo;
		logic [7:0] sat_hi;
		logic [7:0] val_lo;
		logic [7:0] val_hi;
	} hsv_win_t;

	// order is hue lo/hi then sat lo/hi then val lo/hi
	localparam hsv_win_t RED_WIN      = '{8'd5,   8'd17,  8'd196, 8'd255, 8'd113, 8'd255};
	localparam hsv_win_t ORANGE_WIN_A = '{8'd16,  8'd25,  8'd134, 8'd255, 8'd79,  8'd255};
	localparam hsv_win_t ORANGE_WIN_B = '{8'd23,  8'd30,  8'd128, 8'd255, 8'd156, 8'd255};
	localparam hsv_win_t ORANGE_WIN_C = '{8'd23,  8'd30,  8'd153, 8'd255, 8'd253, 8'd255};
	localparam hsv_win_t ORANGE_WIN_D = '{8'd23,  8'd30,  8'd248, 8'd255, 8'd42,  8'd255};
	localparam hsv_win_t TEAL_WIN     = '{8'd60,  8'd85,  8'd101, 8'd199, 8'd111, 8'd244};
	localparam hsv_win_t PINK_WIN_HI  = '{8'd175, 8'd180, 8'd84,  8'd189, 8'd206, 8'd255};
	localparam hsv_win_t PINK_WIN_LO  = '{8'd0,   8'd22,  8'd84,  8'd189, 8'd206, 8'd255};

	//////////////////////////////
	// overlay colours, indexed by ball_color_e
	localparam video_stream_pkg::rgb_t HIGHLIGHT [NUM_BALLS] =
		'{24'hff1000, 24'hea9e1b, 24'h04bd42, 24'hdf55e2};
	localparam video_stream_pkg::rgb_t BOX_COLOR [NUM_BALLS] =
		'{24'hff0000, 24'hffff00, 24'h00ff00, 24'h0000ff};

	//////////////////////////////
	// register map
	localparam int CSR_ADDR_W = 3;
	localparam logic [CSR_ADDR_W-1:0] CSR_STATUS = 3'd0;
	localparam logic [CSR_ADDR_W-1:0] CSR_ID = 3'd1;
	localparam logic [CSR_ADDR_W-1:0] CSR_BOX_BASE = 3'd2; // one word per colour
	localparam logic [31:0] VISION_ID = 32'h1234EEE2;

	typedef struct packed {
		logic chipselect;
		logic read;
		logic [CSR_ADDR_W-1:0] address;
	} csr_req_t;

endpackage

// ==== rtl/ball_vision_top.sv ====
/* ball vision filter top level
   two stream registers around the per-pixel logic, plus tracker and register port */
`timescale 1ns/10ps

module ball_vision_top (
	input  logic clk,
	input  logic reset_n,
	input  video_stream_pkg::stream_beat_t sink_data,
	input  logic sink_valid,
	output logic sink_ready,
	output video_stream_pkg::stream_beat_t source_data,
	output logic source_valid,
	input  logic source_ready,
	input  logic mode,
	input  ball_detect_pkg::csr_req_t csr_req,
	output logic [31:0] readdata
);
	import video_stream_pkg::*;
	import ball_detect_pkg::*;

	stream_beat_t mid_beat;  // beat held in the input stage
	logic mid_valid;
	logic mid_ready;         // output stage can take it
	logic advance;           // mid beat moves this edge
	stream_beat_t ovl_beat;  // processed beat
	hsv_t hsv;
	logic [NUM_BALLS-1:0] confirmed;
	coord_t column;
	logic packet_video;
	box_t [NUM_BALLS-1:0] boxes;
	logic frame_done;

	assign advance = mid_valid & mid_ready;

	//////////////////////////////
	// stream path
	stream_reg in_reg_i (
		.clk(clk), .reset_n(reset_n),
		.in_beat(sink_data), .in_valid(sink_valid), .in_ready(sink_ready),
		.out_beat(mid_beat), .out_valid(mid_valid), .out_ready(mid_ready)
	);

	rgb_to_hsv rgb_to_hsv_i (.pixel(mid_beat.pixel), .hsv(hsv));

	ball_classifier ball_classifier_i (
		.clk(clk), .reset_n(reset_n), .hsv(hsv),
		.header(mid_beat.sop), .advance(advance), .confirmed(confirmed)
	);

	pixel_locator pixel_locator_i (
		.clk(clk), .reset_n(reset_n), .beat(mid_beat), .advance(advance),
		.column(column), .packet_video(packet_video)
	);

	frame_overlay frame_overlay_i (
		.beat(mid_beat), .column(column), .packet_video(packet_video),
		.confirmed(confirmed), .boxes(boxes), .mode(mode), .out_beat(ovl_beat)
	);

	stream_reg out_reg_i (
		.clk(clk), .reset_n(reset_n),
		.in_beat(ovl_beat), .in_valid(mid_valid), .in_ready(mid_ready),
		.out_beat(source_data), .out_valid(source_valid), .out_ready(source_ready)
	);

	//////////////////////////////
	// frame statistics
	box_tracker box_tracker_i (
		.clk(clk), .reset_n(reset_n), .column(column), .packet_video(packet_video),
		.confirmed(confirmed), .header(mid_beat.sop), .eop(mid_beat.eop),
		.advance(advance), .boxes(boxes), .frame_done(frame_done)
	);

	vision_csr vision_csr_i (
		.clk(clk), .reset_n(reset_n), .csr_req(csr_req),
		.boxes(boxes), .frame_done(frame_done), .readdata(readdata)
	);

endmodule

// ==== rtl/box_tracker.sv ====
/* leftmost and rightmost confirmed column per colour within a frame
   edges latch at the end of each video frame for the next frame's overlay */
`timescale 1ns/10ps

module box_tracker (
	input  logic clk,
	input  logic reset_n,
	input  video_stream_pkg::coord_t column,
	input  logic packet_video,
	input  logic [ball_detect_pkg::NUM_BALLS-1:0] confirmed,
	input  logic header,
	input  logic eop,
	input  logic advance,
	output ball_detect_pkg::box_t [ball_detect_pkg::NUM_BALLS-1:0] boxes,
	output logic frame_done
);
	import ball_detect_pkg::*;

	box_t [NUM_BALLS-1:0] bounds;      // running edges of this frame
	box_t [NUM_BALLS-1:0] bounds_next; // including the current pixel

	always_comb begin
		bounds_next = bounds;
		for (int c = 0; c < NUM_BALLS; c++) begin
			if (confirmed[c]) begin
				if (column < bounds[c].left) bounds_next[c].left = column;
				if (column > bounds[c].right) bounds_next[c].right = column;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			bounds <= {NUM_BALLS{BOX_EMPTY}};
			boxes <= {NUM_BALLS{BOX_EMPTY}}; // no lines until a frame ends
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (advance) begin
				if (header) bounds <= {NUM_BALLS{BOX_EMPTY}}; // new packet
				else bounds <= bounds_next;
				if (eop && packet_video && !header) begin
					boxes <= bounds_next; // last pixel counts too
					frame_done <= 1'b1;
				end
			end
		end
	end

	// a drawn box never has its edges crossed
	for (genvar c = 0; c < NUM_BALLS; c++) begin : g_box_chk
		a_box_order: assert property (@(posedge clk) disable iff (!reset_n)
			boxes[c].right != '0 |-> boxes[c].left <= boxes[c].right);
	end

endmodule

// ==== rtl/frame_overlay.sv ====
/* output pixel selection in highlight mode
   grey background, colour highlight and box lines from the previous frame */
`timescale 1ns/10ps

module frame_overlay (
	input  video_stream_pkg::stream_beat_t beat,
	input  video_stream_pkg::coord_t column,
	input  logic packet_video,
	input  logic [ball_detect_pkg::NUM_BALLS-1:0] confirmed,
	input  ball_detect_pkg::box_t [ball_detect_pkg::NUM_BALLS-1:0] boxes,
	input  logic mode, // high for the annotated view
	output video_stream_pkg::stream_beat_t out_beat
);
	import video_stream_pkg::*;
	import ball_detect_pkg::*;

	logic [7:0] grey;
	rgb_t base_px;  // highlight or grey
	rgb_t final_px; // with box lines on top

	assign grey = beat.pixel.green[7:1] + beat.pixel.red[7:2] + beat.pixel.blue[7:2];

	always_comb begin
		if (confirmed[BALL_RED]) base_px = HIGHLIGHT[BALL_RED];
		else if (confirmed[BALL_TEAL]) base_px = HIGHLIGHT[BALL_TEAL];
		else if (confirmed[BALL_ORANGE]) base_px = HIGHLIGHT[BALL_ORANGE];
		else if (confirmed[BALL_PINK]) base_px = HIGHLIGHT[BALL_PINK];
		else base_px = '{grey, grey, grey};

		final_px = base_px;
		for (int c = 0; c < NUM_BALLS; c++) begin // later colours paint over earlier
			if ((column == boxes[c].left && boxes[c].left != coord_t'(IMAGE_W - 1)) ||
				(column == boxes[c].right && boxes[c].right != '0)) begin
				final_px = BOX_COLOR[c];
			end
		end

		out_beat = beat; // sop and eop always pass
		if (mode && !beat.sop && packet_video) begin
			out_beat.pixel = final_px; // descriptor and non-video data untouched
		end
	end

endmodule

// ==== rtl/pixel_locator.sv ====
/* column counter and packet type flag for the beat in the middle of the pipe
   both move only when a beat advances */
`timescale 1ns/10ps

module pixel_locator (
	input  logic clk,
	input  logic reset_n,
	input  video_stream_pkg::stream_beat_t beat,
	input  logic advance,
	output video_stream_pkg::coord_t column,
	output logic packet_video
);
	import video_stream_pkg::*;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			column <= '0;
			packet_video <= 1'b0;
		end else if (advance) begin
			if (beat.sop) begin
				column <= '0; // first pixel follows
				packet_video <= (beat.pixel.blue[3:0] == 4'h0); // descriptor type 0 is video
			end else if (column == coord_t'(IMAGE_W - 1)) begin
				column <= '0; // next row
			end else begin
				column <= column + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/rgb_to_hsv.sv ====
/* combinational RGB to HSV conversion, hue in half degrees
   sits between the stream registers and feeds the classifier */
`timescale 1ns/10ps

module rgb_to_hsv (
	input  video_stream_pkg::rgb_t pixel,
	output ball_detect_pkg::hsv_t hsv
);

	int r, g, b;
	int mx, mn, d; // max, min, spread
	int h;         // hue in whole degrees

	always_comb begin
		r = int'(pixel.red);
		g = int'(pixel.green);
		b = int'(pixel.blue);
		mx = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
		mn = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
		d = mx - mn;

		// sextant formula, numerators never go negative
		if (d == 0) begin
			h = 0; // grey has no hue
		end else if (mx == r) begin
			if (g >= b) h = (60 * (g - b)) / d;
			else h = (360 * d + 60 * (g - b)) / d; // wraps below 360
		end else if (mx == g) begin
			h = (120 * d + 60 * (b - r)) / d;
		end else begin
			h = (240 * d + 60 * (r - g)) / d;
		end

		hsv.hue = 8'(h / 2);
		hsv.sat = (mx == 0) ? 8'd0 : 8'((d * 255) / mx);
		hsv.val = 8'(mx);
	end

endmodule

// ==== rtl/stream_reg.sv ====
/* single registered valid/ready stage for stream beats
   ready passes straight through so a full stage still moves one beat per cycle */
`timescale 1ns/10ps

module stream_reg (
	input  logic clk,
	input  logic reset_n,
	input  video_stream_pkg::stream_beat_t in_beat,
	input  logic in_valid,
	output logic in_ready,
	output video_stream_pkg::stream_beat_t out_beat,
	output logic out_valid,
	input  logic out_ready
);

	// room when empty or when the held beat leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid; // refill or drain
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_beat <= in_beat; // payload moves with the handshake
		end
	end

	// a stalled beat stays put until the consumer takes it
	a_hold_stalled: assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// ==== rtl/video_stream_pkg.sv ====
/* pixel, beat and column types shared by every stage of the video pipeline
   import where stream beats or columns are handled */
package video_stream_pkg;

	//////////////////////////////
	// frame geometry
	localparam int IMAGE_W = 640; // active columns per row
	localparam int COORD_W = 11;  // column counter width

	typedef logic [COORD_W-1:0] coord_t; // one pixel column

	//////////////////////////////
	// stream payload
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t; // 24 bit pixel, red in the top byte

	typedef struct packed {
		rgb_t pixel;
		logic sop; // first beat of a packet, carries the packet descriptor
		logic eop; // last beat of a packet
	} stream_beat_t; // 26 bits

endpackage

// ==== rtl/vision_csr.sv ====
/* memory-mapped read port with ID, finished frame count and latched box edges
   readdata is valid one clock after a read strobe and holds otherwise */
`timescale 1ns/10ps

module vision_csr (
	input  logic clk,
	input  logic reset_n,
	input  ball_detect_pkg::csr_req_t csr_req,
	input  ball_detect_pkg::box_t [ball_detect_pkg::NUM_BALLS-1:0] boxes,
	input  logic frame_done,
	output logic [31:0] readdata
);
	import ball_detect_pkg::*;

	logic [15:0] frame_count; // video frames seen, wraps
	logic [$clog2(NUM_BALLS)-1:0] box_idx;
	logic box_hit;

	assign box_hit = (csr_req.address >= CSR_BOX_BASE) &&
		(csr_req.address < CSR_BOX_BASE + NUM_BALLS);
	assign box_idx = $bits(box_idx)'(csr_req.address - CSR_BOX_BASE);

	always_ff @(posedge clk) begin
		if (!reset_n) frame_count <= '0;
		else if (frame_done) frame_count <= frame_count + 1'b1;
	end

	//////////////////////////////
	// read mux
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
		end else if (csr_req.chipselect && csr_req.read) begin
			if (csr_req.address == CSR_STATUS) begin
				readdata <= {16'h0, frame_count};
			end else if (csr_req.address == CSR_ID) begin
				readdata <= VISION_ID;
			end else if (box_hit) begin
				readdata <= {5'b0, boxes[box_idx].right, 5'b0, boxes[box_idx].left};
			end else begin
				readdata <= '0; // unmapped
			end
		end
	end

	// the host must drive a clean address with every read
	a_addr_known: assert property (@(posedge clk) disable iff (!reset_n)
		csr_req.chipselect && csr_req.read |-> !$isunknown(csr_req.address));

endmodule

// ==== sim.f ====
+incdir+verification
rtl/video_stream_pkg.sv
rtl/ball_detect_pkg.sv
rtl/stream_reg.sv
rtl/rgb_to_hsv.sv
rtl/ball_classifier.sv
rtl/pixel_locator.sv
rtl/box_tracker.sv
rtl/frame_overlay.sv
rtl/vision_csr.sv
rtl/ball_vision_top.sv
verification/ball_vision_tb.sv

// ==== verification/ball_vision_ref.svh ====
/* reference model functions for the ball vision testbench
   included inside the testbench module after the package imports */
`ifndef BALL_VISION_REF_SVH
`define BALL_VISION_REF_SVH

	// hue in half degrees with the sextant chosen by the largest component
	function automatic hsv_t to_hsv(input rgb_t p);
		int r, g, b, mx, mn, d, h;
		hsv_t res;
		r = p.red;
		g = p.green;
		b = p.blue;
		mx = (r > g) ? r : g;
		if (b > mx) mx = b;
		mn = (r < g) ? r : g;
		if (b < mn) mn = b;
		d = mx - mn;
		if (d == 0) h = 0;                                // no hue for grey
		else if (b == mx) h = (240 * d + 60 * (r - g)) / d;
		else if (g == mx) h = (120 * d + 60 * (b - r)) / d;
		else if (g >= b) h = (60 * (g - b)) / d;
		else h = (360 * d + 60 * (g - b)) / d;           // red largest, blue over green
		res.hue = 8'(h / 2);
		res.sat = (mx == 0) ? 8'd0 : 8'((d * 255) / mx);
		res.val = 8'(mx);
		return res;
	endfunction

	// per-colour detector windows
	function automatic logic colour_match(input hsv_t x, input int c);
		int h, s, v;
		h = x.hue;
		s = x.sat;
		v = x.val;
		case (c)
			BALL_RED: return h >= 5 && h <= 17 && s > 195 && v > 112;
			BALL_ORANGE: return (h >= 16 && h <= 25 && s > 133 && v > 78) ||
				(h >= 23 && h <= 30 && ((v > 155 && s > 127) || (s >= 153 && v > 252) ||
				(v > 41 && s > 247)));
			BALL_TEAL: return h >= 60 && h <= 85 && s >= 101 && s <= 199 && v >= 111 && v <= 244;
			default: return (h >= 175 && h <= 180 || h <= 22) && s >= 84 && s <= 189 && v > 205;
		endcase
	endfunction

	function automatic logic [7:0] grey_level(input rgb_t p);
		return 8'(p.green / 2 + p.red / 4 + p.blue / 4);
	endfunction

	// annotated pixel with box lines painted over highlight or grey
	function automatic rgb_t overlay_pixel(input rgb_t p, input int col,
		input logic [NUM_BALLS-1:0] conf, input int bl [NUM_BALLS], input int br [NUM_BALLS]);
		rgb_t px;
		if (conf[BALL_RED]) px = HIGHLIGHT[BALL_RED];
		else if (conf[BALL_TEAL]) px = HIGHLIGHT[BALL_TEAL];
		else if (conf[BALL_ORANGE]) px = HIGHLIGHT[BALL_ORANGE];
		else if (conf[BALL_PINK]) px = HIGHLIGHT[BALL_PINK];
		else px = {3{grey_level(p)}};
		for (int c = 0; c < NUM_BALLS; c++) begin
			if ((col == bl[c] && bl[c] != IMAGE_W - 1) || (col == br[c] && br[c] != 0))
				px = BOX_COLOR[c]; // pink ends on top
		end
		return px;
	endfunction

`endif

// ==== verification/ball_vision_tb.sv ====
/* testbench for the ball vision filter that streams frames through the DUT
   and compares every source beat and register read with a reference model */
`timescale 1ns/10ps

module ball_vision_tb;
	import video_stream_pkg::*;
	import ball_detect_pkg::*;

	`include "ball_vision_ref.svh"

	localparam int PIXELS = 2 * IMAGE_W;                 // two rows per frame
	localparam int MISC_LEN = 20;                        // pixels in the non-video packet
	localparam int TOTAL_BEATS = 3 * (PIXELS + 1) + MISC_LEN + 1;
	localparam int CYCLE_LIMIT = TOTAL_BEATS * 4 + 500;
	localparam int RUN_START [NUM_BALLS] = '{10, 100, 300, 500};
	localparam int RUN_SIZE [NUM_BALLS] = '{20, 30, 25, 30};
	localparam rgb_t BALL_PX [NUM_BALLS] = '{24'he64614, 24'hf0b414, 24'h3cc88c, 24'hf07882};

	logic clk;
	logic reset_n;
	stream_beat_t sink_data;
	logic sink_valid;
	logic sink_ready;
	stream_beat_t source_data;
	logic source_valid;
	logic source_ready;
	logic mode;
	csr_req_t csr_req;
	logic [31:0] readdata;
	logic random_ready; // back-pressure on the source
	stream_beat_t exp_q [$];
	int errors, checks, cycles, tests_run, tests_failed;

	// model state advanced once per sent beat
	int run_cnt [NUM_BALLS];
	int cur_l [NUM_BALLS];
	int cur_r [NUM_BALLS];
	int box_l [NUM_BALLS];
	int box_r [NUM_BALLS];
	int column;
	logic pkt_video;

	ball_vision_top ball_vision_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, beats stopped moving", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		void'($urandom(3));
		source_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1 source_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
		end
	end

	//////////////////////////////
	// scoreboard
	always @(negedge clk) begin
		stream_beat_t want;
		if (reset_n && source_valid && source_ready) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("extra beat %h left the DUT with nothing expected", source_data);
				errors++;
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				assert (source_data == want) else begin
					$display("FAIL t=%0t source_data expected %h got %h", $time, want, source_data);
					errors++;
				end
			end
		end
	end

	task automatic expect_beat(input stream_beat_t b);
		stream_beat_t want;
		logic [NUM_BALLS-1:0] conf;
		hsv_t hsv;
		want = b;
		if (b.sop) begin
			pkt_video = (b.pixel.blue[3:0] == 4'h0);
			column = 0;
			for (int c = 0; c < NUM_BALLS; c++) begin
				run_cnt[c] = 0;
				cur_l[c] = IMAGE_W - 1;
				cur_r[c] = 0;
			end
		end else begin
			hsv = to_hsv(b.pixel);
			for (int c = 0; c < NUM_BALLS; c++) begin
				conf[c] = colour_match(hsv, c) && run_cnt[c] >= RUN_LEN - 1;
				run_cnt[c] = colour_match(hsv, c) ? run_cnt[c] + 1 : 0;
				if (conf[c] && column < cur_l[c]) cur_l[c] = column;
				if (conf[c] && column > cur_r[c]) cur_r[c] = column;
			end
			if (mode && pkt_video) want.pixel = overlay_pixel(b.pixel, column, conf, box_l, box_r);
			if (b.eop && pkt_video) begin
				box_l = cur_l; // lines for the next frame
				box_r = cur_r;
			end
			column = (column == IMAGE_W - 1) ? 0 : column + 1;
		end
		exp_q.push_back(want);
	endtask

	task automatic send_beat(input stream_beat_t b);
		logic taken;
		expect_beat(b);
		sink_data = b;
		sink_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = sink_ready; // handshake completes on the next edge
			@(posedge clk);
			#1;
		end
		sink_valid = 1'b0;
	endtask

	// solid runs per colour plus a three pixel run of each that never confirms
	function automatic rgb_t frame_pixel(input int shift, input int col);
		rgb_t px;
		px = 24'h5a646e;
		for (int c = 0; c < NUM_BALLS; c++) begin
			if (col >= RUN_START[c] + shift && col < RUN_START[c] + shift + RUN_SIZE[c])
				px = BALL_PX[c];
			if (col >= 200 + 10 * c + shift && col < 203 + 10 * c + shift) px = BALL_PX[c];
		end
		return px;
	endfunction

	task automatic send_packet(input int shift, input logic [3:0] ptype, input int npix);
		stream_beat_t b;
		b = '{pixel: {20'h0, ptype}, sop: 1'b1, eop: 1'b0};
		send_beat(b);
		for (int i = 0; i < npix; i++) begin
			if (ptype == 4'h0) b.pixel = frame_pixel(shift, i % IMAGE_W);
			else b.pixel = {8'(i * 37), 8'(i * 11 + 5), 8'(i * 73 + 1)};
			b.sop = 1'b0;
			b.eop = (i == npix - 1);
			send_beat(b);
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0) @(posedge clk);
		repeat (3) @(posedge clk); // frame count settles
		#1;
	endtask

	task automatic check_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] want,
		input string what);
		logic [31:0] got;
		csr_req = '{chipselect: 1'b1, read: 1'b1, address: addr};
		@(posedge clk);
		#1 csr_req = '0;
		@(negedge clk);
		got = readdata;
		checks++;
		assert (got == want) else begin
			$display("FAIL t=%0t readdata (%s) expected %h got %h", $time, what, want, got);
			errors++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	//////////////////////////////
	// test sequence
	initial begin
		int e0;
		int sh;
		reset_n = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		mode = 1'b0;
		csr_req = '0;
		random_ready = 1'b0;
		for (int c = 0; c < NUM_BALLS; c++) begin
			box_l[c] = IMAGE_W - 1; // empty boxes out of reset
			box_r[c] = 0;
		end
		repeat (2) @(posedge clk);
		#1 reset_n = 1'b1;

		e0 = errors;
		send_packet(0, 4'h0, PIXELS);
		drain();
		end_test("passthrough with mode low", e0);

		e0 = errors;
		mode = 1'b1;
		sh = 7;
		send_packet(sh, 4'h0, PIXELS);
		drain();
		for (int c = 0; c < NUM_BALLS; c++) begin
			check_csr(3'(CSR_BOX_BASE + c), {5'b0, 11'(RUN_START[c] + sh + RUN_SIZE[c] - 1),
				5'b0, 11'(RUN_START[c] + sh + RUN_LEN - 1)}, "box edges");
		end
		end_test("highlight, grey and box lines", e0);

		e0 = errors;
		send_packet(0, 4'h3, MISC_LEN);
		drain();
		end_test("non-video packet", e0);

		e0 = errors;
		random_ready = 1'b1;
		send_packet(23, 4'h0, PIXELS);
		drain();
		random_ready = 1'b0;
		end_test("random back-pressure", e0);

		e0 = errors;
		check_csr(CSR_ID, VISION_ID, "id");
		check_csr(CSR_STATUS, 32'd3, "video frame count");
		check_csr(3'd7, 32'd0, "unmapped");
		end_test("register reads", e0);

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
